// File: build.f
+incdir+.
load_pkg.sv
periph_pkg.sv
bus_decoder.sv
ram_port.sv
sd_sector_buffer.sv
key_irq.sv
io_regs.sv
soc_board.sv
tb_soc_board.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_board
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) board_defs.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_soc_board.sv
`timescale 1ns/1ps
`include "board_defs.svh"
`default_nettype none

module tb_soc_board;

    localparam int          RESET_CYCLES   = 8;
    localparam int          READ_LIMIT     = 16;
    localparam int          MAX_ENTRIES    = 160;
    localparam int          RAM_TEST_WORDS = 8;
    localparam int          SD_SECTORS     = 1;
    localparam logic [63:0] RAM_AREA       = `RAM_BASE + 64'h100;

    // Table operations
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_UART  = 2'd2;

    logic        clk;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [2:0]  bus_read_type;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic [7:0]  key_ascii;
    logic        key_pressed;
    logic [7:0]  sd_byte;
    logic        sd_byte_valid;
    logic        sd_ready;
    logic        sd_rd_start;
    logic [31:0] sd_sector;
    logic        uart_strobe;
    logic [7:0]  uart_data;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;

    // Stimulus table
    logic [1:0]  t_op     [MAX_ENTRIES];
    logic [63:0] t_addr   [MAX_ENTRIES];
    logic [63:0] t_wdata  [MAX_ENTRIES];
    logic [2:0]  t_type   [MAX_ENTRIES];
    logic [63:0] t_expect [MAX_ENTRIES];
    int          n_entries;
    int          ram_first;
    int          ram_last;
    int          misc_first;
    bit          table_ready;

    logic [31:0] ram_shadow [RAM_TEST_WORDS + 1];
    logic [7:0]  sd_data [512];
    logic [31:0] rng;
    int          checks;
    int          errors;
    int          uart_count;
    int          start_count;
    int          limit;

    soc_board UUT (
        .CLOCK_50         (clk),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_type    (bus_read_type),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .sd_byte          (sd_byte),
        .sd_byte_valid    (sd_byte_valid),
        .sd_ready         (sd_ready),
        .sd_rd_start      (sd_rd_start),
        .sd_sector        (sd_sector),
        .uart_strobe      (uart_strobe),
        .uart_data        (uart_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // Pulses span a full cycle, so each one meets exactly one falling edge
    always @(negedge clk) begin
        if (uart_strobe) begin
            uart_count++;
        end
        if (sd_rd_start) begin
            start_count++;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Little-endian byte k of the words stored in the test area
    function automatic logic [7:0] byte_at(input int k);
        logic [31:0] w;
        w = ram_shadow[k / 4] >> (8 * (k % 4));
        return w[7:0];
    endfunction

    function automatic logic [63:0] expected_load(input logic [2:0] f3, input int base);
        logic [63:0] raw;
        raw = '0;
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = byte_at(base + i);
        end
        case (f3[1:0])
            2'd0: return f3[2] ? {56'd0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
            2'd1: return f3[2] ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            2'd2: return f3[2] ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    task automatic add_entry(input logic [1:0] op, input logic [63:0] addr,
                             input logic [63:0] wdata, input logic [2:0] ltype,
                             input logic [63:0] expv);
        t_op[n_entries]     = op;
        t_addr[n_entries]   = addr;
        t_wdata[n_entries]  = wdata;
        t_type[n_entries]   = ltype;
        t_expect[n_entries] = expv;
        n_entries++;
    endtask

    task automatic add_ram_read(input int off, input logic [2:0] f3);
        add_entry(OP_READ, RAM_AREA + 64'(off), 64'd0, f3, expected_load(f3, off));
    endtask

    task automatic build_table();
        logic [31:0] r;
        n_entries = 0;
        ram_first = 0;
        // First word fixed so both sign cases appear
        for (int w = 0; w < RAM_TEST_WORDS; w++) begin
            ram_shadow[w] = (w == 0) ? 32'h80FF_7F01 : next_random();
            add_entry(OP_WRITE, RAM_AREA + 64'(4 * w), {32'd0, ram_shadow[w]}, 3'd0, 64'd0);
        end
        ram_shadow[RAM_TEST_WORDS] = 32'd0;
        for (int w = 0; w < RAM_TEST_WORDS; w++) begin
            for (int off = 0; off < 4; off++) begin
                add_ram_read(4 * w + off, 3'b000);
                add_ram_read(4 * w + off, 3'b100);
                if (off % 2 == 0) begin
                    add_ram_read(4 * w + off, 3'b001);
                    add_ram_read(4 * w + off, 3'b101);
                end
            end
            add_ram_read(4 * w, 3'b010);
            add_ram_read(4 * w, 3'b110);
            if (w % 2 == 0) begin
                add_ram_read(4 * w, 3'b011);
            end
        end
        ram_last   = n_entries;
        misc_first = n_entries;
        // ROM, UART and unmapped space read as zero
        add_entry(OP_READ, `ROM_BASE, 64'd0, 3'b011, 64'd0);
        add_entry(OP_READ, `ROM_BASE + 64'h10, 64'd0, 3'b010, 64'd0);
        add_entry(OP_READ, 64'h0000_0000_0000_4000, 64'd0, 3'b011, 64'd0);
        add_entry(OP_READ, 64'hFFFF_FFFF_FFFF_FFF0, 64'd0, 3'b011, 64'd0);
        add_entry(OP_READ, `UART_ADDR, 64'd0, 3'b011, 64'd0);
        add_entry(OP_READ, `SD_BUF_BASE + `SD_BUF_SIZE, 64'd0, 3'b000, 64'd0);
        for (int k = 0; k < 4; k++) begin
            r = next_random();
            add_entry(OP_UART, `UART_ADDR, {32'd0, r}, 3'd0, {56'd0, r[7:0]});
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        @(negedge clk);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge clk);
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_read(input logic [63:0] addr, input logic [2:0] ltype,
                            output logic [63:0] data, output int cycles);
        bit seen;
        @(negedge clk);
        bus_address     = addr;
        bus_read_type   = ltype;
        bus_read_enable = 1'b1;
        cycles          = 0;
        seen            = 1'b0;
        while (!seen && cycles < READ_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = bus_read_done;
        end
        data = bus_read_data;
        // Request stays up through the edge that ends done
        if (seen) begin
            @(negedge clk);
        end
        bus_read_enable = 1'b0;
        if (!seen) begin
            errors++;
            $display("no read done for address %h within %0d cycles", addr, READ_LIMIT);
        end
    endtask

    task automatic feed_sd_byte(input logic [7:0] b);
        @(negedge clk);
        sd_byte       = b;
        sd_byte_valid = 1'b1;
        @(negedge clk);
        sd_byte_valid = 1'b0;
    endtask

    task automatic wait_vector(input logic [3:0] want, input string cause);
        int n;
        n = 0;
        while (interrupt_vector !== want && n < 8) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (interrupt_vector !== want) begin
            errors++;
            $display("FAILED at %0t: interrupt_vector is %0d, not %0d, after %s",
                     $time, interrupt_vector, want, cause);
        end
    endtask

    task automatic apply_entries(input int lo, input int hi);
        logic [63:0] data;
        int          cycles;
        int          strobes;
        bit          is_ram;
        for (int i = lo; i < hi; i++) begin
            case (t_op[i])
                OP_WRITE: begin
                    bus_write(t_addr[i], t_wdata[i]);
                end
                OP_READ: begin
                    bus_read(t_addr[i], t_type[i], data, cycles);
                    check_value($sformatf("load type %0d at %h", t_type[i], t_addr[i]),
                                data, t_expect[i]);
                    is_ram = t_addr[i] >= `RAM_BASE && t_addr[i] < `RAM_BASE + `RAM_SIZE;
                    // Double loads take one beat more than narrower RAM loads
                    if (is_ram) begin
                        check_value("ram read latency", 64'(cycles),
                                    (t_type[i][1:0] == 2'd3) ? 64'd3 : 64'd2);
                    end else begin
                        check_value("device read latency", 64'(cycles), 64'd1);
                    end
                end
                default: begin
                    strobes = uart_count;
                    bus_write(t_addr[i], t_wdata[i]);
                    repeat (2) @(negedge clk);
                    check_value("uart strobes per write", 64'(uart_count - strobes), 64'd1);
                    check_value("uart_data", {56'd0, uart_data}, t_expect[i]);
                end
            endcase
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - err0);
        end
    endtask

    // Run limit scales with the table and the SD traffic
    initial begin
        wait (table_ready);
        limit = RESET_CYCLES + 64 * n_entries + 600 * SD_SECTORS;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [63:0] data;
        logic [31:0] r;
        logic [31:0] sector;
        logic [7:0]  code;
        int          cycles;
        int          err0;
        int          starts;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        bus_read_type    = '0;
        key_ascii        = '0;
        key_pressed      = 1'b0;
        sd_byte          = '0;
        sd_byte_valid    = 1'b0;
        sd_ready         = 1'b0;
        interrupt_ack    = 1'b0;
        checks           = 0;
        errors           = 0;
        uart_count       = 0;
        start_count      = 0;
        rng              = 32'd86317;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        KEY0 = 1'b1;

        err0 = errors;
        bus_read(`SD_AVAIL_REG, 3'b011, data, cycles);
        check_value("sd_avail after reset", data, 64'd0);
        check_value("interrupt_vector after reset", 64'(interrupt_vector), 64'd0);
        check_value("pulse counts after reset", 64'(uart_count + start_count), 64'd0);
        report_test("reset_state", err0);

        err0 = errors;
        apply_entries(ram_first, ram_last);
        report_test("ram_loads", err0);

        err0 = errors;
        r    = next_random();
        code = (r[7:0] == 8'd0) ? 8'h4B : r[7:0];
        @(negedge clk);
        key_ascii   = code;
        key_pressed = 1'b1;
        wait_vector(4'd1, "key press");
        bus_read(`KEY_ADDR, 3'b011, data, cycles);
        check_value("key code", data, {56'd0, code});
        @(negedge clk);
        key_pressed   = 1'b0;
        interrupt_ack = 1'b1;
        @(negedge clk);
        interrupt_ack = 1'b0;
        wait_vector(4'd0, "acknowledge");
        // Zero code must not interrupt
        @(negedge clk);
        key_ascii   = 8'd0;
        key_pressed = 1'b1;
        repeat (6) @(negedge clk);
        check_value("vector after zero-code press", 64'(interrupt_vector), 64'd0);
        key_pressed = 1'b0;
        report_test("key_irq", err0);

        err0   = errors;
        sector = next_random();
        bus_write(`SD_ADDR_REG, {32'd0, sector});
        check_value("sd_sector", {32'd0, sd_sector}, {32'd0, sector});
        starts = start_count;
        bus_write(`SD_READ_REG, 64'd1);
        repeat (3) @(negedge clk);
        check_value("sd_rd_start pulses", 64'(start_count - starts), 64'd1);
        bus_read(`SD_AVAIL_REG, 3'b011, data, cycles);
        check_value("sd_avail before data", data, 64'd0);
        for (int i = 0; i < 512; i++) begin
            r          = next_random();
            sd_data[i] = r[7:0];
            feed_sd_byte(sd_data[i]);
        end
        bus_read(`SD_AVAIL_REG, 3'b011, data, cycles);
        check_value("sd_avail after sector", data, 64'd1);
        sd_ready = 1'b1;
        bus_read(`SD_READY_REG, 3'b011, data, cycles);
        check_value("sd_ready", data, 64'd1);
        sd_ready = 1'b0;
        for (int i = 0; i < 512; i++) begin
            bus_read(`SD_BUF_BASE + 64'(i), 3'b100, data, cycles);
            check_value($sformatf("sd buffer byte %0d", i), data, {56'd0, sd_data[i]});
        end
        // A byte past the sector must leave the buffer alone
        feed_sd_byte(~sd_data[0]);
        bus_read(`SD_BUF_BASE, 3'b100, data, cycles);
        check_value("sd buffer after extra byte", data, {56'd0, sd_data[0]});
        starts = start_count;
        bus_write(`SD_READ_REG, 64'd1);
        repeat (3) @(negedge clk);
        check_value("sd_rd_start on new read", 64'(start_count - starts), 64'd1);
        bus_read(`SD_AVAIL_REG, 3'b011, data, cycles);
        check_value("sd_avail after new read", data, 64'd0);
        report_test("sd_sector", err0);

        err0 = errors;
        apply_entries(misc_first, n_entries);
        report_test("uart_unmapped", err0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_board.sv
`timescale 1ns/1ps
`default_nettype none

module soc_board (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic [63:0]          bus_address,
    input  logic [63:0]          bus_write_data,
    input  logic                 bus_write_enable,
    input  logic                 bus_read_enable,
    input  logic [2:0]           bus_read_type,
    output logic [63:0]          bus_read_data,
    output logic                 bus_read_done,
    input  logic [7:0]           key_ascii,
    input  logic                 key_pressed,
    input  logic [7:0]           sd_byte,
    input  logic                 sd_byte_valid,
    input  logic                 sd_ready,
    output logic                 sd_rd_start,
    output logic [31:0]          sd_sector,
    output logic                 uart_strobe,
    output logic [7:0]           uart_data,
    output periph_pkg::irq_vec_t interrupt_vector,
    input  logic                 interrupt_ack
);

    periph_pkg::region_e region;
    logic                ram_rd_go;
    logic [63:0]         ram_rd_data;
    logic                ram_rd_done;
    logic                ram_wr_en;
    logic [7:0]          key_code;
    logic [8:0]          sd_index;
    logic [7:0]          sd_buf_byte;
    logic                sd_avail;

    // RAM stores bypass the read sequencer
    assign ram_wr_en = bus_write_enable && region == periph_pkg::REGION_RAM;

    bus_decoder u_decoder (
        .bus_address (bus_address),
        .region      (region)
    );

    ram_port u_ram (
        .clk       (CLOCK_50),
        .address   (bus_address),
        .read_type (bus_read_type),
        .rd_go     (ram_rd_go),
        .rd_data   (ram_rd_data),
        .rd_done   (ram_rd_done),
        .wr_en     (ram_wr_en),
        .wr_data   (bus_write_data[31:0])
    );

    sd_sector_buffer u_sd_buf (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .byte_in    (sd_byte),
        .byte_valid (sd_byte_valid),
        .restart    (sd_rd_start),
        .index      (sd_index),
        .byte_out   (sd_buf_byte),
        .avail      (sd_avail)
    );

    key_irq u_key (
        .clk              (CLOCK_50),
        .rst_n            (KEY0),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .interrupt_ack    (interrupt_ack),
        .key_code         (key_code),
        .interrupt_vector (interrupt_vector)
    );

    io_regs u_io (
        .clk              (CLOCK_50),
        .rst_n            (KEY0),
        .region           (region),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .ram_rd_go        (ram_rd_go),
        .ram_rd_data      (ram_rd_data),
        .ram_rd_done      (ram_rd_done),
        .key_code         (key_code),
        .sd_byte          (sd_buf_byte),
        .sd_avail         (sd_avail),
        .sd_ready         (sd_ready),
        .sd_index         (sd_index),
        .sd_rd_start      (sd_rd_start),
        .sd_sector        (sd_sector),
        .uart_strobe      (uart_strobe),
        .uart_data        (uart_data)
    );

endmodule

`default_nettype wire

// File: io_regs.sv
`timescale 1ns/1ps
`include "board_defs.svh"
`default_nettype none

module io_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::region_e region,
    input  logic [63:0]         bus_address,
    input  logic [63:0]         bus_write_data,
    input  logic                bus_write_enable,
    input  logic                bus_read_enable,
    output logic [63:0]         bus_read_data,
    output logic                bus_read_done,
    output logic                ram_rd_go,
    input  logic [63:0]         ram_rd_data,
    input  logic                ram_rd_done,
    input  logic [7:0]          key_code,
    input  logic [7:0]          sd_byte,
    input  logic                sd_avail,
    input  logic                sd_ready,
    output logic [8:0]          sd_index,
    output logic                sd_rd_start,
    output logic [31:0]         sd_sector,
    output logic                uart_strobe,
    output logic [7:0]          uart_data
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_BUSY    = 2'd1;
    localparam logic [1:0] ST_RELEASE = 2'd2;

    logic [1:0]  state;
    logic [63:0] buf_offset;
    logic [63:0] dev_data;
    logic        accept;
    logic        ram_sel;
    logic        dev_load;
    logic        ram_load;
    logic        uart_sel;
    logic        uart_sel_d;

    assign ram_sel    = region == periph_pkg::REGION_RAM;
    assign accept     = state == ST_IDLE && bus_read_enable;
    assign dev_load   = accept && !ram_sel;
    assign ram_load   = state == ST_BUSY && ram_rd_done;
    assign uart_sel   = bus_write_enable && region == periph_pkg::REGION_UART;
    assign buf_offset = bus_address - `SD_BUF_BASE;
    assign sd_index   = buf_offset[8:0];

    // RAM sees the request on the accept edge itself
    assign ram_rd_go  = accept && ram_sel;

    // ROM, UART and unmapped addresses read as zero
    always_comb begin
        case (region)
            periph_pkg::REGION_KEY:      dev_data = {56'd0, key_code};
            periph_pkg::REGION_SD_READY: dev_data = {63'd0, sd_ready};
            periph_pkg::REGION_SD_AVAIL: dev_data = {63'd0, sd_avail};
            periph_pkg::REGION_SD_BUF:   dev_data = {56'd0, sd_byte};
            default:                     dev_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            bus_read_done <= 1'b0;
            sd_rd_start   <= 1'b0;
            sd_sector     <= '0;
            uart_sel_d    <= 1'b0;
            uart_strobe   <= 1'b0;
        end else begin
            bus_read_done <= dev_load || ram_load;
            sd_rd_start   <= bus_write_enable && region == periph_pkg::REGION_SD_READ;
            uart_sel_d    <= uart_sel;
            uart_strobe   <= uart_sel && !uart_sel_d;
            if (bus_write_enable && region == periph_pkg::REGION_SD_ADDR) begin
                sd_sector <= bus_write_data[31:0];
            end
            case (state)
                ST_IDLE: begin
                    if (bus_read_enable) begin
                        state <= ram_sel ? ST_BUSY : ST_RELEASE;
                    end
                end
                ST_BUSY: begin
                    if (ram_rd_done) begin
                        state <= ST_RELEASE;
                    end
                end
                default: begin
                    // Wait for the master to drop its request
                    if (!bus_read_enable) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dev_load) begin
            bus_read_data <= dev_data;
        end else if (ram_load) begin
            bus_read_data <= ram_rd_data;
        end
        if (uart_sel) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    // The master keeps its request up until it has seen done
    assert property (@(posedge clk) disable iff (!rst_n) bus_read_done |-> bus_read_enable)
        else $error("io_regs: read done without a held request");

endmodule

`default_nettype wire

// File: key_irq.sv
`timescale 1ns/1ps
`include "board_defs.svh"
`default_nettype none

module key_irq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           key_ascii,
    input  logic                 key_pressed,
    input  logic                 interrupt_ack,
    output logic [7:0]           key_code,
    output periph_pkg::irq_vec_t interrupt_vector
);

    logic pressed_d;
    logic press_edge;
    logic fresh_q;

    assign press_edge = key_pressed && !pressed_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pressed_d        <= 1'b0;
            fresh_q          <= 1'b0;
            key_code         <= '0;
            interrupt_vector <= '0;
        end else begin
            pressed_d <= key_pressed;
            fresh_q   <= press_edge;
            if (press_edge) begin
                key_code <= key_ascii;
            end
            // A zero code means no printable key, so no interrupt
            if (fresh_q && key_code != 8'd0) begin
                interrupt_vector <= `IRQ_KEY_VECTOR;
            end
            if (interrupt_ack && interrupt_vector != '0) begin
                interrupt_vector <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sd_sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_sector_buffer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    input  logic       restart,
    input  logic [8:0] index,
    output logic [7:0] byte_out,
    output logic       avail
);

    logic [7:0] sector [0:511];
    logic [9:0] count;
    logic       valid_d;
    logic       capture;

    // count[9] marks a full sector, later bytes are dropped
    assign capture = byte_valid && !valid_d && !count[9] && !restart;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            count   <= '0;
            avail   <= 1'b0;
        end else begin
            valid_d <= byte_valid;
            if (restart) begin
                count <= '0;
                avail <= 1'b0;
            end else if (capture) begin
                count <= count + 1'b1;
                if (count == 10'd511) begin
                    avail <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            sector[count[8:0]] <= byte_in;
        end
    end

    assign byte_out = sector[index];

endmodule

`default_nettype wire

// File: ram_port.sv
`timescale 1ns/1ps
`include "board_defs.svh"
`default_nettype none

module ram_port (
    input  logic                 clk,
    input  logic [63:0]          address,
    input  load_pkg::load_type_u read_type,
    input  logic                 rd_go,
    output logic [63:0]          rd_data,
    output logic                 rd_done,
    input  logic                 wr_en,
    input  logic [31:0]          wr_data
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [31:0]          mem [0:`RAM_WORDS-1];
    logic [63:0]          ram_offset;
    logic [IDX_W-1:0]     word_idx;
    logic [IDX_W-1:0]     next_idx;
    logic [1:0]           byte_off;
    load_pkg::load_type_u type_q;
    logic [31:0]          word_q;
    logic [31:0]          low_q;
    logic [31:0]          shifted;
    logic                 is_double;
    logic                 second_q;
    logic                 done_q;

    assign ram_offset = address - `RAM_BASE;
    assign word_idx   = ram_offset[IDX_W+1:2];
    assign is_double  = read_type.fields.size == load_pkg::LOAD_DOUBLE;

    // Stores are whole little-endian words
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= wr_data;
        end
    end

    // Single beat ends one edge after rd_go, a double load one edge later
    always_ff @(posedge clk) begin
        second_q <= rd_go && is_double;
        done_q   <= (rd_go && !is_double) || second_q;
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            word_q   <= mem[word_idx];
            next_idx <= word_idx + 1'b1;
            byte_off <= ram_offset[1:0];
            type_q   <= read_type;
        end else if (second_q) begin
            // Low word moves aside, high word follows
            low_q  <= word_q;
            word_q <= mem[next_idx];
        end
    end

    assign shifted = word_q >> {byte_off, 3'b000};

    always_comb begin
        case (type_q.fields.size)
            load_pkg::LOAD_BYTE: begin
                if (type_q.fields.is_unsigned) begin
                    rd_data = {56'd0, shifted[7:0]};
                end else begin
                    rd_data = {{56{shifted[7]}}, shifted[7:0]};
                end
            end
            load_pkg::LOAD_HALF: begin
                if (type_q.fields.is_unsigned) begin
                    rd_data = {48'd0, shifted[15:0]};
                end else begin
                    rd_data = {{48{shifted[15]}}, shifted[15:0]};
                end
            end
            load_pkg::LOAD_WORD: begin
                if (type_q.fields.is_unsigned) begin
                    rd_data = {32'd0, shifted};
                end else begin
                    rd_data = {{32{shifted[31]}}, shifted};
                end
            end
            default: rd_data = {word_q, low_q};
        endcase
    end

    assign rd_done = done_q;

    // The sequencer in io_regs must not start a load before this one returns
    assert property (@(posedge clk) rd_go |-> !second_q && !done_q)
        else $error("ram_port: rd_go during a read in progress");

endmodule

`default_nettype wire

// File: bus_decoder.sv
`timescale 1ns/1ps
`include "board_defs.svh"
`default_nettype none

module bus_decoder (
    input  logic [63:0]         bus_address,
    output periph_pkg::region_e region
);

    logic [63:0] rom_offset;
    logic [63:0] ram_offset;
    logic [63:0] buf_offset;
    logic        rom_hit;
    logic        ram_hit;
    logic        buf_hit;
    logic        key_hit;
    logic        uart_hit;
    logic        sd_addr_hit;
    logic        sd_read_hit;
    logic        sd_ready_hit;
    logic        sd_avail_hit;

    // Offset wraps below the base, so one compare covers each range
    assign rom_offset = bus_address - `ROM_BASE;
    assign ram_offset = bus_address - `RAM_BASE;
    assign buf_offset = bus_address - `SD_BUF_BASE;

    assign rom_hit      = rom_offset < `ROM_SIZE;
    assign ram_hit      = ram_offset < `RAM_SIZE;
    assign buf_hit      = buf_offset < `SD_BUF_SIZE;
    assign key_hit      = bus_address == `KEY_ADDR;
    assign uart_hit     = bus_address == `UART_ADDR;
    assign sd_addr_hit  = bus_address == `SD_ADDR_REG;
    assign sd_read_hit  = bus_address == `SD_READ_REG;
    assign sd_ready_hit = bus_address == `SD_READY_REG;
    assign sd_avail_hit = bus_address == `SD_AVAIL_REG;

    always_comb begin
        region = periph_pkg::REGION_NONE;
        if (rom_hit) begin
            region = periph_pkg::REGION_ROM;
        end else if (ram_hit) begin
            region = periph_pkg::REGION_RAM;
        end else if (buf_hit) begin
            region = periph_pkg::REGION_SD_BUF;
        end else if (key_hit) begin
            region = periph_pkg::REGION_KEY;
        end else if (uart_hit) begin
            region = periph_pkg::REGION_UART;
        end else if (sd_addr_hit) begin
            region = periph_pkg::REGION_SD_ADDR;
        end else if (sd_read_hit) begin
            region = periph_pkg::REGION_SD_READ;
        end else if (sd_ready_hit) begin
            region = periph_pkg::REGION_SD_READY;
        end else if (sd_avail_hit) begin
            region = periph_pkg::REGION_SD_AVAIL;
        end
    end

    // An overlap in the address map would let the chain above hide a device
    always_comb begin
        assert ($onehot0({rom_hit, ram_hit, buf_hit, key_hit, uart_hit,
                          sd_addr_hit, sd_read_hit, sd_ready_hit, sd_avail_hit}))
            else $error("bus_decoder: overlapping regions at %h", bus_address);
    end

endmodule

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    typedef enum logic [3:0] {
        REGION_NONE     = 4'd0,
        REGION_ROM      = 4'd1,
        REGION_RAM      = 4'd2,
        REGION_KEY      = 4'd3,
        REGION_UART     = 4'd4,
        REGION_SD_ADDR  = 4'd5,
        REGION_SD_READ  = 4'd6,
        REGION_SD_READY = 4'd7,
        REGION_SD_AVAIL = 4'd8,
        REGION_SD_BUF   = 4'd9
    } region_e;

    typedef logic [3:0] irq_vec_t;

endpackage

`default_nettype wire

// File: load_pkg.sv
`default_nettype none

package load_pkg;

    // Access width, low two bits of funct3
    typedef enum logic [1:0] {
        LOAD_BYTE   = 2'd0,
        LOAD_HALF   = 2'd1,
        LOAD_WORD   = 2'd2,
        LOAD_DOUBLE = 2'd3
    } load_size_e;

    // funct3 bit 2 selects zero extension
    typedef struct packed {
        logic       is_unsigned;
        load_size_e size;
    } load_fields_t;

    // Raw funct3 from the bus, or its decoded fields
    typedef union packed {
        logic [2:0]   funct3;
        load_fields_t fields;
    } load_type_u;

endpackage

`default_nettype wire

// File: board_defs.svh
`default_nettype none

`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Memory regions, byte addresses
`define ROM_BASE        64'h0000_0000_0000_0000
`define ROM_SIZE        64'h0000_0000_0000_1000
`define RAM_BASE        64'h0000_0000_0000_1000
`define RAM_SIZE        64'h0000_0000_0000_1000

// RAM depth in 32-bit words, RAM_SIZE / 4
`define RAM_WORDS       1024

// Single device registers
`define KEY_ADDR        64'h0000_0000_0000_8000
`define UART_ADDR       64'h0000_0000_0000_8008
`define SD_ADDR_REG     64'h0000_0000_0000_8010
`define SD_READ_REG     64'h0000_0000_0000_8018
`define SD_READY_REG    64'h0000_0000_0000_8020
`define SD_AVAIL_REG    64'h0000_0000_0000_8028

// SD sector buffer window, one byte per address
`define SD_BUF_BASE     64'h0000_0000_0000_9000
`define SD_BUF_SIZE     64'h0000_0000_0000_0200

// Vector raised by a key press
`define IRQ_KEY_VECTOR  4'd1

`endif

`default_nettype wire
